// ==== hw/display_timing.sv ====
// display timing for 640x480 at 60 Hz
// pixel and line counters with registered sync and data enable

`timescale 1ns/1ps
`default_nettype none

`include "starfield_consts.svh"

module display_timing import starfield_pkg::*; (
    input  wire logic   clk_pix,
    input  wire logic   rst,
    output coord_t      sx,         // current pixel column
    output coord_t      sy,         // current line
    output logic        hsync,      // active low
    output logic        vsync,      // active low
    output logic        de          // visible area
);

    // line layout
    localparam coord_t H_ACT   = coord_t'(`H_RES);
    localparam coord_t HS_FROM = coord_t'(`H_RES + `H_FP);                // 656
    localparam coord_t HS_TO   = coord_t'(`H_RES + `H_FP + `H_SYNC - 1);  // 751
    localparam coord_t H_LAST  = coord_t'(`H_RES + `H_FP + `H_SYNC + `H_BP - 1);

    // frame layout
    localparam coord_t V_ACT   = coord_t'(`V_RES);
    localparam coord_t VS_FROM = coord_t'(`V_RES + `V_FP);                // 490
    localparam coord_t VS_TO   = coord_t'(`V_RES + `V_FP + `V_SYNC - 1);  // 491
    localparam coord_t V_LAST  = coord_t'(`V_RES + `V_FP + `V_SYNC + `V_BP - 1);

    logic   running;    // low for the first edge after reset, holds (0,0) once
    coord_t sx_next;
    coord_t sy_next;

    // next position
    always_comb begin
        sx_next = sx;
        sy_next = sy;
        if (!running) begin
            sx_next = '0;   // present pixel (0,0) right after release
            sy_next = '0;
        end else if (sx == H_LAST) begin
            sx_next = '0;
            sy_next = (sy == V_LAST) ? '0 : sy + 1'b1;  // wrap at end of frame
        end else begin
            sx_next = sx + 1'b1;
        end
    end

    // counters and decoded signals share one register stage
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            running <= 1'b0;
            sx      <= '0;
            sy      <= '0;
            hsync   <= 1'b1;    // idle high
            vsync   <= 1'b1;
            de      <= 1'b0;
        end else begin
            running <= 1'b1;
            sx      <= sx_next;
            sy      <= sy_next;
            // decode from next state so they line up with sx and sy
            hsync   <= !((sx_next >= HS_FROM) && (sx_next <= HS_TO));
            vsync   <= !((sy_next >= VS_FROM) && (sy_next <= VS_TO));
            de      <= (sx_next < H_ACT) && (sy_next < V_ACT);
        end
    end

endmodule

`default_nettype wire

// ==== hw/lfsr.sv ====
// Galois LFSR
// one step per enabled clock, loads the seed on reset

`timescale 1ns/1ps
`default_nettype none

module lfsr #(
    parameter int             LEN  = 8,                         // state width
    parameter logic [LEN-1:0] TAPS = 8'b1011_1000,              // feedback mask
    parameter logic [LEN-1:0] SEED = {{(LEN-1){1'b0}}, 1'b1}    // must not be zero
) (
    input  wire logic   clk_pix,
    input  wire logic   rst,
    input  wire logic   en,         // advance this cycle
    output logic [LEN-1:0] sreg     // current state
);

    logic [LEN-1:0] sreg_next;

    // shift right, fold taps in when bit 0 drops out as one
    always_comb begin
        sreg_next = {1'b0, sreg[LEN-1:1]};
        if (sreg[0]) begin
            sreg_next = sreg_next ^ TAPS;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sreg <= SEED;
        end else if (en) begin
            sreg <= sreg_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/star_field.sv ====
// star field generator
// LFSR stepped across the star region, thresholded into stars

`timescale 1ns/1ps
`default_nettype none

`include "starfield_consts.svh"

module star_field import starfield_pkg::*; (
    input  wire logic   clk_pix,
    input  wire logic   rst,
    input  wire coord_t sx,             // pixel position from timing
    input  wire coord_t sy,
    input  wire logic   de,             // visible area
    output logic        star,           // star at this pixel
    output colour_t     star_level      // its brightness
);

    localparam coord_t SF_X_END = coord_t'(`SF_W);
    localparam coord_t SF_Y_END = coord_t'(`SF_H);

    logic  sf_area;     // pixel inside the star region
    lfsr_t sf_reg;      // generator state for this pixel

    // region test, also the LFSR step enable
    always_comb begin
        sf_area = de && (sx < SF_X_END) && (sy < SF_Y_END);
    end

    // free running across frames, only rst brings it back to the seed
    lfsr #(
        .LEN  (`STAR_LFSR_LEN),
        .TAPS (`STAR_LFSR_TAPS),
        .SEED (`STAR_LFSR_SEED)
    ) u_lfsr (
        .clk_pix (clk_pix),
        .rst     (rst),
        .en      (sf_area),
        .sreg    (sf_reg)
    );

    // state seen here is from before this pixel's own step
    always_comb begin
        // density, about one star every 256 region pixels
        star       = sf_area && (&sf_reg[`STAR_LFSR_LEN-1 -: `STAR_THRESH_BITS]);
        star_level = sf_reg[$bits(colour_t)-1:0];   // low bits give grey level
    end

endmodule

`default_nettype wire

// ==== hw/starfield_consts.svh ====
// starfield constants
// 640x480 video timing, star region size and LFSR setup

`ifndef STARFIELD_CONSTS_SVH
`define STARFIELD_CONSTS_SVH

// horizontal timing in pixels, 800 per line
`define H_RES   640
`define H_FP    16
`define H_SYNC  96     // hsync low for sx 656..751
`define H_BP    48

// vertical timing in lines, 525 per frame
`define V_RES   480
`define V_FP    10
`define V_SYNC  2      // vsync low for sy 490..491
`define V_BP    33

// star region at the top-left of the picture
`define SF_W    512
`define SF_H    256

// star generator LFSR
`define STAR_LFSR_LEN    17
`define STAR_LFSR_TAPS   17'b1_0010_0000_0000_0000   // bits 16 and 13
`define STAR_LFSR_SEED   17'd1                       // non-zero, no lock-up
`define STAR_THRESH_BITS 8                           // top bits all set gives a star

`endif

// ==== hw/starfield_pkg.sv ====
// starfield types
// vector typedefs shared by the design and its testbench

`default_nettype none

`include "starfield_consts.svh"

package starfield_pkg;

    typedef logic [15:0] coord_t;                   // screen position, sx or sy
    typedef logic [3:0]  colour_t;                  // one VGA channel
    typedef logic [`STAR_LFSR_LEN-1:0] lfsr_t;      // star generator state

endpackage

`default_nettype wire

// ==== hw/starfield_top.sv ====
// VGA starfield top level
// timing generator and star field feeding the output register stage

`timescale 1ns/1ps
`default_nettype none

module starfield_top import starfield_pkg::*; (
    input  wire logic   clk_pix,    // pixel clock, 25.175 MHz nominal
    input  wire logic   rst,
    output logic        vga_hsync,
    output logic        vga_vsync,
    output colour_t     vga_r,
    output colour_t     vga_g,
    output colour_t     vga_b
);

    coord_t  sx;
    coord_t  sy;
    logic    hsync;
    logic    vsync;
    logic    de;
    logic    star;
    colour_t star_level;

    display_timing u_timing (
        .clk_pix (clk_pix),
        .rst     (rst),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de)
    );

    star_field u_star (
        .clk_pix    (clk_pix),
        .rst        (rst),
        .sx         (sx),
        .sy         (sy),
        .de         (de),
        .star       (star),
        .star_level (star_level)
    );

    // one cycle behind the timing outputs
    vga_output u_out (
        .clk_pix    (clk_pix),
        .rst        (rst),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de),
        .star       (star),
        .star_level (star_level),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b)
    );

endmodule

`default_nettype wire

// ==== hw/vga_output.sv ====
// VGA output stage
// registers sync and grey star level onto the VGA pins

`timescale 1ns/1ps
`default_nettype none

module vga_output import starfield_pkg::*; (
    input  wire logic    clk_pix,
    input  wire logic    rst,
    input  wire logic    hsync,
    input  wire logic    vsync,
    input  wire logic    de,
    input  wire logic    star,
    input  wire colour_t star_level,
    output logic         vga_hsync,
    output logic         vga_vsync,
    output colour_t      vga_r,
    output colour_t      vga_g,
    output colour_t      vga_b
);

    colour_t grey;  // level shown at this pixel

    // black in blanking and between stars
    always_comb begin
        grey = (de && star) ? star_level : '0;
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync;
            vga_vsync <= vsync;
            vga_r     <= grey;  // same level on all three, no colour
            vga_g     <= grey;
            vga_b     <= grey;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/starfield_pkg.sv
hw/lfsr.sv
hw/display_timing.sv
hw/star_field.sv
hw/vga_output.sv
hw/starfield_top.sv
tests/tb_starfield.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the starfield testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_starfield -f project.f

# the simulator exit status is not used, the log is searched instead
./obj_dir/Vtb_starfield > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "FAIL: testbench reported errors, see sim.log"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "FAIL: no pass line in sim.log"
    exit 1
fi
echo "PASS"

// ==== tests/tb_starfield.sv ====
// starfield testbench
// reset scenarios from a table with every output pixel checked against
// a pixel position and Galois LFSR model

`timescale 1ns/1ps
`default_nettype none

`include "starfield_consts.svh"

module tb_starfield import starfield_pkg::*; ();

    localparam int CLK_PERIOD   = 4;    // ns
    localparam int RST_CYCLES   = 3;
    localparam int H_TOTAL      = `H_RES + `H_FP + `H_SYNC + `H_BP;    // 800
    localparam int V_TOTAL      = `V_RES + `V_FP + `V_SYNC + `V_BP;    // 525
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;                  // 420000
    localparam int HS_FROM      = `H_RES + `H_FP;                     // 656
    localparam int HS_TO        = HS_FROM + `H_SYNC - 1;              // 751
    localparam int VS_FROM      = `V_RES + `V_FP;                     // 490
    localparam int VS_TO        = VS_FROM + `V_SYNC - 1;              // 491
    localparam int N_SCEN       = 4;

    // scenario table
    // name, cycles before the mid-frame reset (0 draws a random count), frames checked after
    string scen_name   [N_SCEN] = '{"reset_mid_line", "reset_random_a",
                                    "reset_near_vsync", "reset_random_b"};
    int    scen_pre    [N_SCEN] = '{1000, 0, 391800, 0};    // 391800 is line 489 sx 600
    int    scen_frames [N_SCEN] = '{1, 1, 1, 2};            // two frames with no reseed between

    logic    clk_pix;
    logic    rst;
    logic    vga_hsync;
    logic    vga_vsync;
    colour_t vga_r;
    colour_t vga_g;
    colour_t vga_b;

    // model of the pixel currently on the pins
    int     mx;
    int     my;
    lfsr_t  m_lfsr;
    int     star_count;             // stars seen since the last reset
    integer seed = 32'h1db6_4a88;

    starfield_top u_dut (
        .clk_pix   (clk_pix),
        .rst       (rst),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pix = ~clk_pix;
    end

    // one Galois step with taps folded in when a one drops out of bit 0
    function automatic lfsr_t galois_next(input lfsr_t s);
        lfsr_t n;
        n = s >> 1;     // zero enters at the top
        if (s[0]) begin
            n = n ^ lfsr_t'(`STAR_LFSR_TAPS);
        end
        return n;
    endfunction

    // visible and inside the 512x256 star region
    function automatic logic in_star_region(input int x, input int y);
        return (x < `H_RES) && (y < `V_RES) && (x < `SF_W) && (y < `SF_H);
    endfunction

    task automatic stop_on_error(input string why);
        $display("Finished with errors");
        $fatal(1, "%s", why);
    endtask

    task automatic check_sync(input string name, input string what,
                              input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected %0b, got %0b", name, what, exp, act);
            stop_on_error("sync mismatch");
        end
    endtask

    task automatic check_colour(input string name, input string what,
                                input colour_t exp, input colour_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected 0x%0h, got 0x%0h", name, what, exp, act);
            stop_on_error("colour mismatch");
        end
    endtask

    task automatic check_coord(input string name, input string what,
                               input coord_t exp, input coord_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected %0d, got %0d", name, what, exp, act);
            stop_on_error("position mismatch");
        end
    endtask

    // pins at their reset values
    task automatic check_idle(input string name);
        check_sync(name, "vga_hsync", 1'b1, vga_hsync);
        check_sync(name, "vga_vsync", 1'b1, vga_vsync);
        check_colour(name, "vga_r", '0, vga_r);
        check_colour(name, "vga_g", '0, vga_g);
        check_colour(name, "vga_b", '0, vga_b);
    endtask

    // reset for RST_CYCLES edges and restart the model at (0,0) and the seed
    task automatic apply_reset(input string name);
        int i;
        @(posedge clk_pix);
        rst <= 1'b1;
        for (i = 0; i < RST_CYCLES; i++) begin
            @(posedge clk_pix);
            if (i == RST_CYCLES - 1) begin
                rst <= 1'b0;    // DUT still sees high on this edge
            end
            @(negedge clk_pix);
            check_idle(name);
        end
        @(negedge clk_pix);     // output stage still idle on the first edge after release
        check_idle(name);
        check_coord(name, "timing sx", '0, u_dut.u_timing.sx);     // (0,0) presented now
        check_coord(name, "timing sy", '0, u_dut.u_timing.sy);
        mx         = 0;
        my         = 0;
        m_lfsr     = `STAR_LFSR_SEED;
        star_count = 0;
    endtask

    // one output pixel compared after the edge that registered it
    task automatic check_pixel(input string name);
        logic    exp_hs;
        logic    exp_vs;
        logic    exp_star;
        colour_t exp_col;
        @(negedge clk_pix);
        exp_hs   = !((mx >= HS_FROM) && (mx <= HS_TO));    // active low
        exp_vs   = !((my >= VS_FROM) && (my <= VS_TO));
        exp_star = in_star_region(mx, my)
                   && (&m_lfsr[`STAR_LFSR_LEN-1 -: `STAR_THRESH_BITS]);
        exp_col  = exp_star ? m_lfsr[3:0] : '0;    // grey from the low bits
        check_sync(name, "vga_hsync", exp_hs, vga_hsync);
        check_sync(name, "vga_vsync", exp_vs, vga_vsync);
        check_colour(name, "vga_r", exp_col, vga_r);
        check_colour(name, "vga_g", exp_col, vga_g);
        check_colour(name, "vga_b", exp_col, vga_b);
        if (exp_star) begin
            star_count++;
        end
        // LFSR moves only on region pixels and is never reseeded at frame end
        if (in_star_region(mx, my)) begin
            m_lfsr = galois_next(m_lfsr);
        end
        if (mx == H_TOTAL - 1) begin
            mx = 0;
            my = (my == V_TOTAL - 1) ? 0 : my + 1;
        end else begin
            mx = mx + 1;
        end
        // timing generator sits one pixel ahead of the pins
        check_coord(name, "timing sx", coord_t'(mx), u_dut.u_timing.sx);
        check_coord(name, "timing sy", coord_t'(my), u_dut.u_timing.sy);
    endtask

    initial begin : main
        int s;
        int c;
        int pre;
        rst = 1'b1;
        apply_reset("power_on");
        for (s = 0; s < N_SCEN; s++) begin
            pre = scen_pre[s];
            if (pre == 0) begin
                pre = 1 + int'($unsigned($random(seed)) % (FRAME_CYCLES - 1));
            end
            $display("scenario %s: reset after %0d cycles, then %0d frame(s)",
                     scen_name[s], pre, scen_frames[s]);
            for (c = 0; c < pre; c++) begin
                check_pixel(scen_name[s]);  // continues from the previous scenario
            end
            apply_reset(scen_name[s]);
            for (c = 0; c < scen_frames[s] * FRAME_CYCLES; c++) begin
                check_pixel(scen_name[s]);
            end
            $display("scenario %s: %0d stars matched", scen_name[s], star_count);
        end
        $display("Finished with no errors");
        $finish;
    end

    // run limit with one spare frame per scenario for its pre-reset cycles
    initial begin : watchdog
        int     i;
        longint limit;
        limit = RST_CYCLES + 2;     // power-on reset
        for (i = 0; i < N_SCEN; i++) begin
            limit += longint'(scen_frames[i] + 1) * FRAME_CYCLES + RST_CYCLES + 2;
        end
        limit += 10000;             // margin
        #(limit * CLK_PERIOD);
        $display("timeout: simulation still running after %0d clock cycles", limit);
        stop_on_error("watchdog timeout");
    end

endmodule

`default_nettype wire
